/* Makefile */
# Verilator build and run for the global buffer testbench

TOP := glb_top_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o $(TOP)

# the log must hold the pass line, otherwise the target fails
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/glb_bank.sv */
//**********************************************************
// per-tile register bank, 16 words, async read
//**********************************************************
`timescale 1ns/1ps

module glb_bank (
    input  logic        clk,
    input  logic        clk_en,
    input  logic        reset,
    glb_bank_if.bank_mp bank
);
    import glb_param_pkg::*;

    localparam int DEPTH = 2 ** BANK_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // every word reads zero after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (clk_en && bank.we) begin
            mem[bank.addr] <= bank.wdata;
        end
    end

    assign bank.rdata = mem[bank.addr];

endmodule

/* design/glb_bank_if.sv */
//**********************************************************
// bank access port between a core switch and its bank
//**********************************************************
`timescale 1ns/1ps

interface glb_bank_if;
    import glb_param_pkg::*;

    logic                       we;
    logic [BANK_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]      wdata;
    // read data comes back in the same cycle
    logic [DATA_WIDTH-1:0]      rdata;

    modport switch_mp (output we, addr, wdata, input rdata);
    modport bank_mp (input we, addr, wdata, output rdata);

endinterface

/* design/glb_core_strm_router.sv */
//**********************************************************
// per-tile stream router, one per tile
// even tiles serve eastbound, odd tiles serve westbound
//**********************************************************
`timescale 1ns/1ps

module glb_core_strm_router #(
    parameter int TILE_ID = 0
) (
    input  logic                     clk,
    input  logic                     clk_en,
    input  logic                     reset,
    input  logic                     cfg_tile_connected_prev,
    input  logic                     cfg_tile_connected_next,
    input  glb_packet_pkg::packet_t  packet_w2e_wsti,
    output glb_packet_pkg::packet_t  packet_e2w_wsto,
    input  glb_packet_pkg::packet_t  packet_e2w_esti,
    output glb_packet_pkg::packet_t  packet_w2e_esto,
    input  glb_packet_pkg::packet_t  packet_sw2sr,
    output glb_packet_pkg::packet_t  packet_sr2sw
);
    import glb_packet_pkg::*;

    // tile numbering starts at 0, so tile 0 is even
    localparam bit IS_EVEN = (TILE_ID % 2) == 0;

    packet_t west_in;
    packet_t east_in;
    packet_t sw_out_q;

    // unconnected side loops our own outgoing packet back in
    assign west_in = cfg_tile_connected_prev ? packet_w2e_wsti : packet_e2w_wsto;
    assign east_in = cfg_tile_connected_next ? packet_e2w_esti : packet_w2e_esto;

    // switch output register, the only stage in a tile
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sw_out_q <= '0;
        end else if (clk_en) begin
            sw_out_q <= packet_sw2sr;
        end
    end

    // served direction goes through the switch, the other passes straight
    assign packet_sr2sw    = IS_EVEN ? west_in : east_in;
    assign packet_w2e_esto = IS_EVEN ? sw_out_q : west_in;
    assign packet_e2w_wsto = IS_EVEN ? east_in : sw_out_q;

endmodule

/* design/glb_core_switch.sv */
//**********************************************************
// per-tile core switch, serves requests for this tile
// and forwards every other packet unchanged
//**********************************************************
`timescale 1ns/1ps

module glb_core_switch #(
    parameter int TILE_ID = 0
) (
    input  glb_packet_pkg::packet_t  packet_in,
    output glb_packet_pkg::packet_t  packet_out,
    glb_bank_if.switch_mp            bank
);
    import glb_param_pkg::*;
    import glb_packet_pkg::*;

    localparam logic [TILE_SEL_ADDR_WIDTH-1:0] MY_TILE = TILE_SEL_ADDR_WIDTH'(TILE_ID);

    logic is_req;
    logic hit;

    assign is_req = (packet_in.op == OP_WR_REQ) || (packet_in.op == OP_RD_REQ);
    // live request addressed here
    assign hit = packet_in.valid && is_req && (packet_in.tile == MY_TILE);

    // bank only sees a write for a matching write request
    assign bank.we    = hit && (packet_in.op == OP_WR_REQ);
    assign bank.addr  = packet_in.addr;
    assign bank.wdata = packet_in.data;

    always_comb begin
        packet_out = packet_in;
        if (hit) begin
            if (packet_in.op == OP_WR_REQ) begin
                // write echoes its own data back
                packet_out.op = OP_WR_RSP;
            end else begin
                packet_out.op   = OP_RD_RSP;
                packet_out.data = bank.rdata;
            end
        end
    end

endmodule

/* design/glb_packet_pkg.sv */
//**********************************************************
// packet format carried along the tile chain
// opcode enum plus the 41-bit packet struct
//**********************************************************
package glb_packet_pkg;

    // requests from the host, responses from the addressed tile
    typedef enum logic [1:0] {
        OP_WR_REQ = 2'd0,
        OP_RD_REQ = 2'd1,
        OP_WR_RSP = 2'd2,
        OP_RD_RSP = 2'd3
    } packet_op_e;

    // valid marks a live packet, no back-pressure anywhere
    typedef struct packed {
        logic                                           valid;
        packet_op_e                                     op;
        logic [glb_param_pkg::TILE_SEL_ADDR_WIDTH-1:0]  tile;
        logic [glb_param_pkg::BANK_ADDR_WIDTH-1:0]      addr;
        logic [glb_param_pkg::DATA_WIDTH-1:0]           data;
    } packet_t;

endpackage

/* design/glb_param_pkg.sv */
//**********************************************************
// width constants shared by the global buffer blocks
// import where address or data widths are needed
//**********************************************************
package glb_param_pkg;

    // tile select field, up to 4 tiles
    localparam int TILE_SEL_ADDR_WIDTH = 2;

    // word address inside one bank, 16 words
    localparam int BANK_ADDR_WIDTH = 4;

    localparam int DATA_WIDTH = 32;

    // host word address = tile select on top of bank address
    localparam int ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH;

endpackage

/* design/glb_tile.sv */
//**********************************************************
// one buffer tile: router, core switch and bank
//**********************************************************
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID = 0
) (
    input  logic                     clk,
    input  logic                     clk_en,
    input  logic                     reset,
    input  logic                     cfg_tile_connected_prev,
    input  logic                     cfg_tile_connected_next,
    input  glb_packet_pkg::packet_t  packet_w2e_wsti,
    output glb_packet_pkg::packet_t  packet_e2w_wsto,
    input  glb_packet_pkg::packet_t  packet_e2w_esti,
    output glb_packet_pkg::packet_t  packet_w2e_esto
);
    import glb_packet_pkg::*;

    // router to switch and back
    packet_t packet_sr2sw;
    packet_t packet_sw2sr;

    glb_bank_if bank_if ();

    glb_core_strm_router #(
        .TILE_ID (TILE_ID)
    ) i_router (
        .clk                     (clk),
        .clk_en                  (clk_en),
        .reset                   (reset),
        .cfg_tile_connected_prev (cfg_tile_connected_prev),
        .cfg_tile_connected_next (cfg_tile_connected_next),
        .packet_w2e_wsti         (packet_w2e_wsti),
        .packet_e2w_wsto         (packet_e2w_wsto),
        .packet_e2w_esti         (packet_e2w_esti),
        .packet_w2e_esto         (packet_w2e_esto),
        .packet_sw2sr            (packet_sw2sr),
        .packet_sr2sw            (packet_sr2sw)
    );

    glb_core_switch #(
        .TILE_ID (TILE_ID)
    ) i_switch (
        .packet_in  (packet_sr2sw),
        .packet_out (packet_sw2sr),
        .bank       (bank_if.switch_mp)
    );

    glb_bank i_bank (
        .clk    (clk),
        .clk_en (clk_en),
        .reset  (reset),
        .bank   (bank_if.bank_mp)
    );

endmodule

/* design/glb_top.sv */
//**********************************************************
// global buffer top: Wishbone front-end and tile chain
// NUM_TILES sets the chain length, 1 to 4
//**********************************************************
`timescale 1ns/1ps

module glb_top #(
    parameter int NUM_TILES = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 clk_en,
    input  logic                                 cyc,
    input  logic                                 stb,
    input  logic                                 we,
    input  logic [glb_param_pkg::ADDR_WIDTH-1:0] adr,
    input  logic [glb_param_pkg::DATA_WIDTH-1:0] dat_w,
    output logic [glb_param_pkg::DATA_WIDTH-1:0] dat_r,
    output logic                                 ack
);
    import glb_packet_pkg::*;

    // link i sits west of tile i, link NUM_TILES east of the last
    packet_t w2e_link [NUM_TILES+1];
    packet_t e2w_link [NUM_TILES+1];

    // nothing beyond the last tile
    assign e2w_link[NUM_TILES] = '0;

    glb_wb_front #(
        .NUM_TILES (NUM_TILES)
    ) i_front (
        .clk        (clk),
        .clk_en     (clk_en),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_w      (dat_w),
        .dat_r      (dat_r),
        .ack        (ack),
        .packet_out (w2e_link[0]),
        .packet_in  (e2w_link[0])
    );

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        // front-end always sits west of tile 0, last tile turns around
        glb_tile #(
            .TILE_ID (i)
        ) i_tile (
            .clk                     (clk),
            .clk_en                  (clk_en),
            .reset                   (reset),
            .cfg_tile_connected_prev (1'b1),
            .cfg_tile_connected_next (i != NUM_TILES - 1),
            .packet_w2e_wsti         (w2e_link[i]),
            .packet_e2w_wsto         (e2w_link[i]),
            .packet_e2w_esti         (e2w_link[i+1]),
            .packet_w2e_esto         (w2e_link[i+1])
        );
    end

endmodule

/* design/glb_wb_front.sv */
//**********************************************************
// Wishbone classic slave front-end, one request in flight
// sends a request packet into tile 0, acks on its return
//**********************************************************
`timescale 1ns/1ps

module glb_wb_front #(
    parameter int NUM_TILES = 4
) (
    input  logic                                 clk,
    input  logic                                 clk_en,
    input  logic                                 reset,
    input  logic                                 cyc,
    input  logic                                 stb,
    input  logic                                 we,
    input  logic [glb_param_pkg::ADDR_WIDTH-1:0] adr,
    input  logic [glb_param_pkg::DATA_WIDTH-1:0] dat_w,
    output logic [glb_param_pkg::DATA_WIDTH-1:0] dat_r,
    output logic                                 ack,
    output glb_packet_pkg::packet_t              packet_out,
    input  glb_packet_pkg::packet_t              packet_in
);
    import glb_param_pkg::*;
    import glb_packet_pkg::*;

    typedef enum logic [1:0] {
        FRONT_IDLE,
        FRONT_WAIT,
        FRONT_ACK
    } front_state_e;

    front_state_e state;
    logic         issued;
    // request targets a tile that exists
    logic         pend_served;

    logic [TILE_SEL_ADDR_WIDTH-1:0] tile_sel;
    logic                           in_range;
    logic                           rsp_hit;
    packet_t                        req_pkt;

    assign tile_sel = adr[ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH];
    assign in_range = tile_sel < NUM_TILES;

    // out-of-range requests come back still as requests
    assign rsp_hit = packet_in.valid
                   && ((packet_in.op == OP_WR_RSP) || (packet_in.op == OP_RD_RSP)
                       || !pend_served);

    // bus is held by the master until ack, so build from it directly
    always_comb begin
        req_pkt       = '0;
        req_pkt.valid = 1'b1;
        req_pkt.op    = we ? OP_WR_REQ : OP_RD_REQ;
        req_pkt.tile  = tile_sel;
        req_pkt.addr  = adr[BANK_ADDR_WIDTH-1:0];
        req_pkt.data  = dat_w;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= FRONT_IDLE;
            issued      <= 1'b0;
            pend_served <= 1'b0;
            packet_out  <= '0;
            ack         <= 1'b0;
        end else begin
            // ack drops on the next edge even while stalled
            ack <= 1'b0;
            if (clk_en) begin
                // request packet lives for one cycle only
                packet_out <= (state == FRONT_WAIT && !issued) ? req_pkt : '0;
                case (state)
                    FRONT_WAIT: begin
                        if (!issued) begin
                            issued      <= 1'b1;
                            pend_served <= in_range;
                        end else if (rsp_hit) begin
                            ack   <= 1'b1;
                            state <= FRONT_ACK;
                        end
                    end
                    // ack cycle can already accept the next request
                    default: begin
                        issued <= 1'b0;
                        state  <= (cyc && stb) ? FRONT_WAIT : FRONT_IDLE;
                    end
                endcase
            end
        end
    end

    // response data, written alongside ack
    always_ff @(posedge clk) begin
        if (clk_en && state == FRONT_WAIT && issued && rsp_hit) begin
            dat_r <= packet_in.data;
        end
    end

endmodule

/* tb.f */
design/glb_param_pkg.sv
design/glb_packet_pkg.sv
design/glb_bank_if.sv
design/glb_bank.sv
design/glb_core_switch.sv
design/glb_core_strm_router.sv
design/glb_tile.sv
design/glb_wb_front.sv
design/glb_top.sv
verification/glb_clk_gen.sv
verification/glb_top_props.sv
verification/glb_top_tb.sv

/* verification/glb_clk_gen.sv */
//**********************************************************
// free-running testbench clock, PERIOD_NS sets the period
//**********************************************************
`timescale 1ns/1ps

module glb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    // starts low, first rising edge half a period in
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* verification/glb_top_props.sv */
//**********************************************************
// Wishbone handshake checks, bound onto the buffer top level
//**********************************************************
`timescale 1ns/1ps

module glb_top_props (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack
);

    // count of failed assertions
    int failures = 0;

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else begin
            $error("ack held high for more than one cycle");
            failures++;
        end

    // cyc and stb were active on the edge that raised ack
    ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
        ack |-> $past(cyc && stb))
        else begin
            $error("ack raised without an active cyc and stb");
            failures++;
        end

    // async reset keeps ack cleared
    ack_low_in_reset: assert property (@(posedge clk) reset |-> !ack)
        else begin
            $error("ack high while reset is asserted");
            failures++;
        end

endmodule

bind glb_top glb_top_props i_props (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .ack   (ack)
);

/* verification/glb_top_tb.sv */
//**********************************************************
// directed testbench for the global buffer tile chain
// drives the Wishbone port, checks data and ack latency
//**********************************************************
`timescale 1ns/1ps

module glb_top_tb;
    import glb_param_pkg::*;

    localparam int NUM_TILES  = 4;
    localparam int CLK_PERIOD = 4;
    localparam int WORDS      = 2 ** BANK_ADDR_WIDTH;
    // request register, one stage per tile, response register
    localparam int LATENCY    = NUM_TILES + 2;
    localparam int MAX_STALL  = 6;
    localparam int NUM_STALL  = 3;
    localparam int NUM_RANDOM = 40;
    // bus cycles of all tests together
    localparam int NUM_TRANS  = NUM_TILES * WORDS + 4 + 4 * NUM_TILES + NUM_STALL + NUM_RANDOM;
    localparam int WATCHDOG_NS = (NUM_TRANS * (LATENCY + 10) + 200) * CLK_PERIOD;

    logic                  clk;
    logic                  reset;
    logic                  clk_en;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] dat_w;
    logic [DATA_WIDTH-1:0] dat_r;
    logic                  ack;

    // expected contents per tile and word
    logic [DATA_WIDTH-1:0] ref_mem [NUM_TILES][WORDS];

    string test_name;
    int    test_errors = 0;
    int    errors      = 0;
    int    tests_run   = 0;
    int    checks      = 0;

    glb_clk_gen #(
        .PERIOD_NS (CLK_PERIOD)
    ) i_clk_gen (
        .clk (clk)
    );

    glb_top #(
        .NUM_TILES (NUM_TILES)
    ) i_glb_top (
        .clk    (clk),
        .reset  (reset),
        .clk_en (clk_en),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_w  (dat_w),
        .dat_r  (dat_r),
        .ack    (ack)
    );

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d error(s)", test_name, test_errors);
        end
    endtask

    task automatic check_data(input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("CHECK FAILED %s: data expected 0x%08h, actual 0x%08h",
                     test_name, expected, actual);
        end
    endtask

    task automatic check_count(input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            test_errors++;
            $display("CHECK FAILED %s: cycles expected %0d, actual %0d",
                     test_name, expected, actual);
        end
    endtask

    task automatic check_flag(input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            test_errors++;
            $display("CHECK FAILED %s: ack expected %b, actual %b", test_name, expected, actual);
        end
    endtask

    // one classic cycle with cycles counted from the edge that samples stb
    task automatic run_bus_cycle(input logic write, input int tile, input int addr,
                                 input logic [DATA_WIDTH-1:0] wdata,
                                 output logic [DATA_WIDTH-1:0] rdata, output int cycles);
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = {TILE_SEL_ADDR_WIDTH'(tile), BANK_ADDR_WIDTH'(addr)};
        dat_w = wdata;
        @(posedge clk);
        cycles = 0;
        @(negedge clk);
        while (!ack) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        rdata = dat_r;
        // release before the next edge so the slave stays idle
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wb_write(input int tile, input int addr, input logic [DATA_WIDTH-1:0] data,
                            output logic [DATA_WIDTH-1:0] echo, output int cycles);
        run_bus_cycle(1'b1, tile, addr, data, echo, cycles);
    endtask

    task automatic wb_read(input int tile, input int addr,
                           output logic [DATA_WIDTH-1:0] data, output int cycles);
        run_bus_cycle(1'b0, tile, addr, '0, data, cycles);
    endtask

    // write ack returns the written word
    task automatic write_word(input int tile, input int addr,
                              input logic [DATA_WIDTH-1:0] data, output int cycles);
        logic [DATA_WIDTH-1:0] echo;
        wb_write(tile, addr, data, echo, cycles);
        check_data(data, echo);
        ref_mem[tile][addr] = data;
    endtask

    task automatic read_word(input int tile, input int addr, output int cycles);
        logic [DATA_WIDTH-1:0] data;
        wb_read(tile, addr, data, cycles);
        check_data(ref_mem[tile][addr], data);
    endtask

    task automatic test_reset();
        int cycles;
        start_test("reset");
        // two rising edges with reset held
        repeat (2) begin
            @(negedge clk);
            check_flag(1'b0, ack);
        end
        reset = 1'b0;
        for (int t = 0; t < NUM_TILES; t++) begin
            for (int a = 0; a < WORDS; a++) begin
                ref_mem[t][a] = '0;
                read_word(t, a, cycles);
            end
        end
        finish_test();
    endtask

    task automatic test_write_read();
        int cycles;
        start_test("write_read");
        write_word(1, 5, $urandom, cycles);
        read_word(1, 5, cycles);
        // last word of the turnaround tile
        write_word(NUM_TILES - 1, WORDS - 1, $urandom, cycles);
        read_word(NUM_TILES - 1, WORDS - 1, cycles);
        finish_test();
    endtask

    task automatic test_isolation();
        int cycles;
        start_test("isolation");
        // same word in every tile covers even and odd paths
        for (int t = 0; t < NUM_TILES; t++) begin
            write_word(t, 7, DATA_WIDTH'(32'h1111_1111 * (t + 1)), cycles);
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            read_word(t, 7, cycles);
        end
        finish_test();
    endtask

    task automatic test_latency();
        int cycles;
        start_test("latency");
        for (int t = 0; t < NUM_TILES; t++) begin
            write_word(t, t + 2, $urandom, cycles);
            check_count(LATENCY, cycles);
            read_word(t, t + 2, cycles);
            check_count(LATENCY, cycles);
        end
        finish_test();
    endtask

    task automatic test_stall();
        int tile;
        int addr;
        int stall;
        int cycles;
        start_test("stall");
        for (int i = 0; i < NUM_STALL; i++) begin
            tile  = $urandom_range(NUM_TILES - 1, 0);
            addr  = $urandom_range(WORDS - 1, 0);
            stall = $urandom_range(MAX_STALL, 1);
            fork
                read_word(tile, addr, cycles);
                // clk_en drops just after stb was sampled
                begin
                    repeat (2) @(negedge clk);
                    clk_en = 1'b0;
                    repeat (stall) @(negedge clk);
                    clk_en = 1'b1;
                end
            join
            check_count(LATENCY + stall, cycles);
        end
        finish_test();
    endtask

    task automatic test_random();
        int tile;
        int addr;
        int cycles;
        start_test("random");
        for (int i = 0; i < NUM_RANDOM; i++) begin
            tile = $urandom_range(NUM_TILES - 1, 0);
            addr = $urandom_range(WORDS - 1, 0);
            if ($urandom_range(1, 0) == 1) begin
                write_word(tile, addr, $urandom, cycles);
            end else begin
                read_word(tile, addr, cycles);
            end
        end
        finish_test();
    endtask

    // bounds the run if an ack never comes
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the DUT stopped answering bus cycles");
        $display("Test failures found");
        $finish;
    end

    initial begin
        reset  = 1'b1;
        clk_en = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        void'($urandom(41));
        test_reset();
        test_write_read();
        test_isolation();
        test_latency();
        test_stall();
        test_random();
        // failed handshake assertions count as errors too
        errors += i_glb_top.i_props.failures;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
